// File: Makefile
# Verilator build and run for the spectral block testbench

VERILATOR ?= verilator
TOP       ?= fft_block_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^TB PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/block_settings.sv
// Settings register file for the spectral block
// Turns settings-bus writes into held direction and output-mode levels
`timescale 1ns/1ns

module block_settings import fft_pkg::*; (
  input  logic        bus_clk,
  input  logic        arst_n,
  input  logic        set_stb,
  input  logic [7:0]  set_addr,
  input  logic [31:0] set_data,
  output logic        inverse,
  output logic        mag_mode
);

  // Forward direction and complex output out of reset
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      inverse  <= 1'b0;
      mag_mode <= 1'b0;
    end else if (set_stb) begin
      // Only bit 0 of each register is meaningful
      case (set_addr)
        SR_DIRECTION: begin
          inverse <= set_data[0];
        end
        SR_OUT_MODE: begin
          mag_mode <= set_data[0];
        end
        default: begin
          // Unknown address, write dropped
        end
      endcase
    end
  end

endmodule

// File: hdl/dft_engine.sv
// Sequential eight-point DFT engine
// Eight multiply-accumulate cycles and one emit cycle per bin, 1/N scaled
`timescale 1ns/1ns

module dft_engine import fft_pkg::*; (
  input  logic      bus_clk,
  input  logic      arst_n,
  input  logic      full0,
  input  logic      full1,
  input  logic      inverse,
  input  logic      mag_mode,
  output logic      rd_half,
  output idx_t      rd_idx,
  input  cplx_t     rd_data,
  output logic      release_half,
  output logic      out_valid,
  output logic      out_last,
  output bin_word_t out_data
);

  typedef enum logic [1:0] {
    idle,
    accumulate,
    emit
  } state_t;

  state_t  state;
  idx_t    bin_k;
  idx_t    smp_n;
  idx_t    tw_q;
  logic    acc_vld;
  logic    inv_q;
  logic    mag_q;
  logic    older;
  logic    full0_q;
  logic    full1_q;
  logic    avail0;
  logic    avail1;
  logic    pick;
  acc_t    acc_re;
  acc_t    acc_im;
  acc_t    prod_re;
  acc_t    prod_im;
  acc_t    sum_re;
  acc_t    sum_im;
  sample_t smp_re;
  sample_t smp_im;
  sample_t tw_c;
  sample_t tw_s;
  sample_t sh_re;
  sample_t sh_im;
  logic [31:0] sq_re;
  logic [31:0] sq_im;

  assign rd_idx = smp_n;

  // The half being released still reads full on this cycle
  assign avail0 = full0 & ~(release_half & ~rd_half);
  assign avail1 = full1 & ~(release_half & rd_half);
  assign pick   = (avail0 && avail1) ? older : avail1 & ~avail0;

  // Sample times twiddle, sine negated for the forward transform
  always_comb begin
    smp_re  = rd_data[31:16];
    smp_im  = rd_data[15:0];
    tw_c    = COS_TAB[tw_q];
    tw_s    = inv_q ? SIN_TAB[tw_q] : -SIN_TAB[tw_q];
    prod_re = smp_re * tw_c - smp_im * tw_s;
    prod_im = smp_re * tw_s + smp_im * tw_c;
    // Final sample lands during emit, so fold it in here
    sum_re  = acc_re + prod_re;
    sum_im  = acc_im + prod_im;
    // Truncating shift back to Q15
    sh_re   = sample_t'(sum_re >>> SCALE_SHIFT);
    sh_im   = sample_t'(sum_im >>> SCALE_SHIFT);
    sq_re   = sh_re * sh_re;
    sq_im   = sh_im * sh_im;
  end

  // Track which full half was committed first
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      full0_q <= 1'b0;
      full1_q <= 1'b0;
      older   <= 1'b0;
    end else begin
      full0_q <= full0;
      full1_q <= full1;
      if (full0 && !full0_q && !full1) begin
        older <= 1'b0;
      end else if (full1 && !full1_q && !full0) begin
        older <= 1'b1;
      end else if (!full0 && full0_q && full1) begin
        older <= 1'b1;
      end else if (!full1 && full1_q && full0) begin
        older <= 1'b0;
      end
    end
  end

  // Control FSM and output strobes
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= idle;
      rd_half      <= 1'b0;
      bin_k        <= '0;
      smp_n        <= '0;
      tw_q         <= '0;
      acc_vld      <= 1'b0;
      inv_q        <= 1'b0;
      mag_q        <= 1'b0;
      out_valid    <= 1'b0;
      out_last     <= 1'b0;
      release_half <= 1'b0;
    end else begin
      // Read issued now, sample arrives next cycle
      acc_vld      <= (state == accumulate);
      tw_q         <= bin_k * smp_n;
      out_valid    <= (state == emit);
      out_last     <= (state == emit) && (bin_k == idx_t'(FRAME_LEN - 1));
      release_half <= (state == emit) && (bin_k == idx_t'(FRAME_LEN - 1));
      case (state)
        idle: begin
          if (avail0 || avail1) begin
            // Settings held for the whole frame
            rd_half <= pick;
            inv_q   <= inverse;
            mag_q   <= mag_mode;
            bin_k   <= '0;
            smp_n   <= '0;
            state   <= accumulate;
          end
        end
        accumulate: begin
          smp_n <= smp_n + 1'b1;
          if (smp_n == idx_t'(FRAME_LEN - 1)) begin
            state <= emit;
          end
        end
        emit: begin
          if (bin_k == idx_t'(FRAME_LEN - 1)) begin
            state <= idle;
          end else begin
            bin_k <= bin_k + 1'b1;
            state <= accumulate;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Accumulators cleared between bins
  always_ff @(posedge bus_clk) begin
    if (state != accumulate) begin
      acc_re <= '0;
      acc_im <= '0;
    end else if (acc_vld) begin
      acc_re <= sum_re;
      acc_im <= sum_im;
    end
    if (state == emit) begin
      out_data <= mag_q ? (sq_re + sq_im) : {sh_re, sh_im};
    end
  end

endmodule

// File: hdl/fft_block.sv
// Eight-point spectral analysis block
// Settings, frame capture, ping-pong store and DFT engine
`timescale 1ns/1ns

module fft_block import fft_pkg::*; (
  input  logic        bus_clk,
  input  logic        arst_n,
  input  logic        set_stb,
  input  logic [7:0]  set_addr,
  input  logic [31:0] set_data,
  input  logic        in_valid,
  input  cplx_t       in_data,
  input  logic        in_last,
  output logic        out_valid,
  output bin_word_t   out_data,
  output logic        out_last,
  output logic        frame_err,
  output logic        overflow
);

  logic  inverse;
  logic  mag_mode;
  logic  wr_en;
  logic  wr_half;
  idx_t  wr_idx;
  cplx_t wr_data;
  logic  commit;
  logic  full0;
  logic  full1;
  logic  rd_half;
  idx_t  rd_idx;
  cplx_t rd_data;
  logic  release_half;

  block_settings u_settings (
    .bus_clk  (bus_clk),
    .arst_n   (arst_n),
    .set_stb  (set_stb),
    .set_addr (set_addr),
    .set_data (set_data),
    .inverse  (inverse),
    .mag_mode (mag_mode)
  );

  // Producer side
  frame_capture u_capture (
    .bus_clk   (bus_clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .in_data   (in_data),
    .full0     (full0),
    .full1     (full1),
    .wr_en     (wr_en),
    .wr_half   (wr_half),
    .wr_idx    (wr_idx),
    .wr_data   (wr_data),
    .commit    (commit),
    .frame_err (frame_err),
    .overflow  (overflow)
  );

  sample_store u_store (
    .bus_clk      (bus_clk),
    .arst_n       (arst_n),
    .wr_en        (wr_en),
    .wr_half      (wr_half),
    .wr_idx       (wr_idx),
    .wr_data      (wr_data),
    .commit       (commit),
    .rd_half      (rd_half),
    .rd_idx       (rd_idx),
    .rd_data      (rd_data),
    .release_half (release_half),
    .full0        (full0),
    .full1        (full1)
  );

  // Consumer side
  dft_engine u_engine (
    .bus_clk      (bus_clk),
    .arst_n       (arst_n),
    .full0        (full0),
    .full1        (full1),
    .inverse      (inverse),
    .mag_mode     (mag_mode),
    .rd_half      (rd_half),
    .rd_idx       (rd_idx),
    .rd_data      (rd_data),
    .release_half (release_half),
    .out_valid    (out_valid),
    .out_last     (out_last),
    .out_data     (out_data)
  );

endmodule

// File: hdl/fft_pkg.sv
// Shared definitions for the eight-point spectral block
// Sample and bin types, frame length, settings addresses and twiddle tables
package fft_pkg;

  // One Q15 component
  typedef logic signed [15:0] sample_t;
  // Complex sample, real part in [31:16], imaginary part in [15:0]
  typedef logic [31:0] cplx_t;
  // Output word, complex bin or unsigned squared magnitude
  typedef logic [31:0] bin_word_t;
  // Accumulator for eight complex Q15 products
  typedef logic signed [35:0] acc_t;
  // Sample or bin index within a frame
  typedef logic [2:0] idx_t;

  localparam int FRAME_LEN = 8;

  // Settings register addresses
  localparam logic [7:0] SR_DIRECTION = 8'd0;
  localparam logic [7:0] SR_OUT_MODE  = 8'd1;

  // Q30 sums back to Q15 with 1/8 scaling
  localparam int SCALE_SHIFT = 18;

  // Q15 cos and sin of 2*pi*m/8
  localparam sample_t COS_TAB [FRAME_LEN] = '{
    16'sd32767, 16'sd23170, 16'sd0, -16'sd23170,
    -16'sd32767, -16'sd23170, 16'sd0, 16'sd23170
  };
  localparam sample_t SIN_TAB [FRAME_LEN] = '{
    16'sd0, 16'sd23170, 16'sd32767, 16'sd23170,
    16'sd0, -16'sd23170, -16'sd32767, -16'sd23170
  };

endpackage

// File: hdl/frame_capture.sv
// Frame capture stage
// Checks in_last placement, claims a free store half and writes the samples
`timescale 1ns/1ns

module frame_capture import fft_pkg::*; (
  input  logic  bus_clk,
  input  logic  arst_n,
  input  logic  in_valid,
  input  logic  in_last,
  input  cplx_t in_data,
  input  logic  full0,
  input  logic  full1,
  output logic  wr_en,
  output logic  wr_half,
  output idx_t  wr_idx,
  output cplx_t wr_data,
  output logic  commit,
  output logic  frame_err,
  output logic  overflow
);

  idx_t pos;
  logic cur_half;
  logic drop_q;
  logic busy0;
  logic busy1;
  logic first;
  logic last_pos;
  logic end_now;
  logic good_now;
  logic drop_now;
  logic claim_half;

  // A half committed this cycle shows its full flag only on the next one
  assign busy0 = full0 | (commit & ~cur_half);
  assign busy1 = full1 | (commit & cur_half);

  // Position zero means the next sample opens a new frame
  assign first      = (pos == '0);
  assign claim_half = busy0;
  assign drop_now   = first ? (busy0 & busy1) : drop_q;

  // Good framing is in_last on exactly the eighth sample
  assign last_pos = (pos == idx_t'(FRAME_LEN - 1));
  assign end_now  = in_last | last_pos;
  assign good_now = in_last & last_pos;

  // Samples go straight into the store at their index
  assign wr_en   = in_valid & ~drop_now;
  assign wr_half = first ? claim_half : cur_half;
  assign wr_idx  = pos;
  assign wr_data = in_data;

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      pos       <= '0;
      cur_half  <= 1'b0;
      drop_q    <= 1'b0;
      commit    <= 1'b0;
      frame_err <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      // Fault and commit strobes last a single cycle
      commit    <= 1'b0;
      frame_err <= 1'b0;
      overflow  <= 1'b0;
      if (in_valid) begin
        if (first && !drop_now) begin
          cur_half <= claim_half;
        end
        if (end_now) begin
          pos       <= '0;
          drop_q    <= 1'b0;
          commit    <= good_now & ~drop_now;
          frame_err <= ~good_now;
          overflow  <= drop_now;
        end else begin
          pos    <= pos + 1'b1;
          drop_q <= drop_now;
        end
      end
    end
  end

endmodule

// File: hdl/sample_store.sv
// Ping-pong sample store with two frame halves
// Registered read port and one full flag per half
`timescale 1ns/1ns

module sample_store import fft_pkg::*; (
  input  logic  bus_clk,
  input  logic  arst_n,
  input  logic  wr_en,
  input  logic  wr_half,
  input  idx_t  wr_idx,
  input  cplx_t wr_data,
  input  logic  commit,
  input  logic  rd_half,
  input  idx_t  rd_idx,
  output cplx_t rd_data,
  input  logic  release_half,
  output logic  full0,
  output logic  full1
);

  // Half select is the top address bit
  cplx_t mem [2*FRAME_LEN];
  logic  last_half;

  always_ff @(posedge bus_clk) begin
    if (wr_en) begin
      mem[{wr_half, wr_idx}] <= wr_data;
    end
    // Data for rd_idx shows up one cycle later
    rd_data <= mem[{rd_half, rd_idx}];
  end

  // Commit marks the half that took the latest write
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      last_half <= 1'b0;
      full0     <= 1'b0;
      full1     <= 1'b0;
    end else begin
      if (wr_en) begin
        last_half <= wr_half;
      end
      if (commit && !last_half) begin
        full0 <= 1'b1;
      end else if (release_half && !rd_half) begin
        full0 <= 1'b0;
      end
      if (commit && last_half) begin
        full1 <= 1'b1;
      end else if (release_half && rd_half) begin
        full1 <= 1'b0;
      end
    end
  end

endmodule

// File: testbench/fft_block_properties.sv
// Protocol assertions on the spectral block ports
// Attached to every fft_block instance by bind
`timescale 1ns/1ns

module fft_block_properties (
  input logic bus_clk,
  input logic arst_n,
  input logic out_valid,
  input logic out_last,
  input logic frame_err,
  input logic overflow
);

  // Cycles since the last output strobe, zero before the first one
  logic [3:0] since_valid;

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      since_valid <= '0;
    end else if (out_valid) begin
      since_valid <= 4'd1;
    end else if (since_valid != 4'd0 && since_valid != 4'd15) begin
      since_valid <= since_valid + 4'd1;
    end
  end

  last_with_valid: assert property (@(posedge bus_clk) disable iff (!arst_n)
    out_last |-> out_valid)
    else $error("out_last seen without out_valid");

  quiet_in_reset: assert property (@(posedge bus_clk) !arst_n |-> !out_valid)
    else $error("out_valid seen while reset is asserted");

  err_single: assert property (@(posedge bus_clk) disable iff (!arst_n)
    frame_err |=> !frame_err)
    else $error("frame_err held longer than one cycle");

  ovf_single: assert property (@(posedge bus_clk) disable iff (!arst_n)
    overflow |=> !overflow)
    else $error("overflow held longer than one cycle");

  // Bins are nine cycles apart at the closest
  bin_spacing: assert property (@(posedge bus_clk) disable iff (!arst_n)
    (out_valid && since_valid != 4'd0) |-> (since_valid >= 4'd9))
    else $error("two out_valid strobes closer than nine cycles");

endmodule

bind fft_block fft_block_properties u_props (
  .bus_clk   (bus_clk),
  .arst_n    (arst_n),
  .out_valid (out_valid),
  .out_last  (out_last),
  .frame_err (frame_err),
  .overflow  (overflow)
);

// File: testbench/fft_block_tb.sv
// Testbench for the eight-point spectral block
// Replays frame records from the pattern file and checks bins and fault pulses
`timescale 1ns/1ns

module fft_block_tb import fft_pkg::*; ();

  localparam int MAX_RECS    = 16;
  localparam int BIN_TIMEOUT = 200;

  logic        bus_clk;
  logic        arst_n;
  logic        set_stb;
  logic [7:0]  set_addr;
  logic [31:0] set_data;
  logic        in_valid;
  cplx_t       in_data;
  logic        in_last;
  logic        out_valid;
  bin_word_t   out_data;
  logic        out_last;
  logic        frame_err;
  logic        overflow;

  int errors     = 0;
  int checks     = 0;
  int err_pulses = 0;
  int ovf_pulses = 0;

  // One entry per frame record
  int        rec_dir   [MAX_RECS];
  int        rec_mode  [MAX_RECS];
  int        rec_last  [MAX_RECS];
  int        rec_space [MAX_RECS];
  cplx_t     rec_in    [MAX_RECS][FRAME_LEN];
  bin_word_t rec_exp   [MAX_RECS][FRAME_LEN];
  int        rec_count = 0;

  fft_block u_dut (
    .bus_clk   (bus_clk),
    .arst_n    (arst_n),
    .set_stb   (set_stb),
    .set_addr  (set_addr),
    .set_data  (set_data),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_last   (in_last),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_last  (out_last),
    .frame_err (frame_err),
    .overflow  (overflow)
  );

  initial begin
    bus_clk = 1'b0;
    forever begin
      #20 bus_clk = ~bus_clk;
    end
  end

  // Running count of frame_err and overflow pulses
  always @(negedge bus_clk) begin
    if (frame_err === 1'b1) begin
      err_pulses++;
    end
    if (overflow === 1'b1) begin
      ovf_pulses++;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic load_patterns();
    int        fd;
    int        phase;
    int        got;
    string     line;
    bin_word_t w [FRAME_LEN];
    phase = 0;
    fd = $fopen("testbench/fft_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open pattern file testbench/fft_patterns.txt");
    end else begin
      while (!$feof(fd) && rec_count < MAX_RECS) begin
        got = $fgets(line, fd);
        // Comment and blank lines carry no data
        if (got > 1 && line.getc(0) != "#") begin
          if (phase == 0) begin
            got = $sscanf(line, "%d %d %d %d", rec_dir[rec_count], rec_mode[rec_count],
                          rec_last[rec_count], rec_space[rec_count]);
            if (got != 4) begin
              errors++;
              $display("malformed header line in pattern file: %s", line);
            end
            phase = 1;
          end else begin
            got = $sscanf(line, "%h %h %h %h %h %h %h %h",
                          w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
            if (got != FRAME_LEN) begin
              errors++;
              $display("malformed word line in pattern file: %s", line);
            end
            for (int k = 0; k < FRAME_LEN; k++) begin
              if (phase == 1) begin
                rec_in[rec_count][k] = w[k];
              end else begin
                rec_exp[rec_count][k] = w[k];
              end
            end
            if (phase == 1) begin
              phase = 2;
            end else begin
              phase = 0;
              rec_count++;
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic write_setting(input logic [7:0] addr, input int value);
    @(posedge bus_clk);
    #2;
    set_stb  = 1'b1;
    set_addr = addr;
    set_data = 32'(value);
    @(posedge bus_clk);
    #2;
    set_stb  = 1'b0;
    set_addr = '0;
    set_data = '0;
  endtask

  task automatic apply_settings(input int r);
    write_setting(SR_DIRECTION, rec_dir[r]);
    write_setting(SR_OUT_MODE, rec_mode[r]);
  endtask

  // Leaves the last sample on the bus so a following frame can run back-to-back
  task automatic send_frame(input int r);
    int n_smp;
    n_smp = (rec_last[r] < FRAME_LEN) ? rec_last[r] : FRAME_LEN;
    for (int s = 0; s < n_smp; s++) begin
      @(posedge bus_clk);
      #2;
      in_valid = 1'b1;
      in_data  = rec_in[r][s];
      in_last  = (s == rec_last[r] - 1);
    end
  endtask

  task automatic stop_input();
    @(posedge bus_clk);
    #2;
    in_valid = 1'b0;
    in_last  = 1'b0;
    in_data  = '0;
  endtask

  task automatic wait_valid(output bit found);
    int waited;
    found  = 1'b0;
    waited = 0;
    while (!found && waited < BIN_TIMEOUT) begin
      @(negedge bus_clk);
      if (out_valid === 1'b1) begin
        found = 1'b1;
      end else begin
        waited++;
      end
    end
  endtask

  task automatic collect_frame(input int r);
    bit found;
    bit abort;
    abort = 1'b0;
    for (int b = 0; b < FRAME_LEN; b++) begin
      if (!abort) begin
        wait_valid(found);
        if (!found) begin
          errors++;
          $display("timeout waiting for output bin %0d of record %0d", b, r);
          abort = 1'b1;
        end else begin
          check_value($sformatf("out_data rec %0d bin %0d", r, b), out_data, rec_exp[r][b]);
          check_value($sformatf("out_last rec %0d bin %0d", r, b), 32'(out_last),
                      32'(b == FRAME_LEN - 1));
        end
      end
    end
  endtask

  // Settings written while bins are coming out belong to the next frame
  task automatic change_settings_mid_frame(input int r);
    bit found;
    wait_valid(found);
    if (found) begin
      write_setting(SR_DIRECTION, 1 - rec_dir[r]);
      write_setting(SR_OUT_MODE, 1 - rec_mode[r]);
    end
  endtask

  task automatic expect_quiet(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge bus_clk);
      check_value("out_valid", 32'(out_valid), 32'h0);
    end
  endtask

  task automatic expect_idle(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge bus_clk);
      check_value("out_valid", 32'(out_valid), 32'h0);
      check_value("out_last", 32'(out_last), 32'h0);
      check_value("frame_err", 32'(frame_err), 32'h0);
      check_value("overflow", 32'(overflow), 32'h0);
    end
  endtask

  // Send one frame and wait for its bins or for its fault pulse
  task automatic run_single(input int r);
    int err0;
    int ovf0;
    err0 = err_pulses;
    ovf0 = ovf_pulses;
    apply_settings(r);
    send_frame(r);
    stop_input();
    if (rec_last[r] == FRAME_LEN) begin
      fork
        collect_frame(r);
        change_settings_mid_frame(r);
      join
      expect_quiet(12);
      check_value("frame_err pulses", 32'(err_pulses - err0), 32'h0);
    end else begin
      expect_quiet(100);
      check_value("frame_err pulses", 32'(err_pulses - err0), 32'h1);
    end
    check_value("overflow pulses", 32'(ovf_pulses - ovf0), 32'h0);
  endtask

  // Back-to-back frames at one sample per cycle overrun the two store halves
  task automatic run_burst(input int first, input int n);
    int err0;
    int ovf0;
    int n_out;
    err0  = err_pulses;
    ovf0  = ovf_pulses;
    n_out = (n < 2) ? n : 2;
    apply_settings(first);
    fork
      begin
        for (int f = 0; f < n; f++) begin
          send_frame(first + f);
        end
        stop_input();
      end
      begin
        for (int f = 0; f < n_out; f++) begin
          collect_frame(first + f);
        end
      end
    join
    expect_quiet(100);
    check_value("overflow pulses", 32'(ovf_pulses - ovf0), 32'(n - n_out));
    check_value("frame_err pulses", 32'(err_pulses - err0), 32'h0);
  endtask

  initial begin
    int i;
    int j;
    arst_n   = 1'b0;
    set_stb  = 1'b0;
    set_addr = '0;
    set_data = '0;
    in_valid = 1'b0;
    in_data  = '0;
    in_last  = 1'b0;
    load_patterns();
    if (rec_count == 0) begin
      errors++;
      $display("no frame records loaded from the pattern file");
    end
    repeat (5) @(posedge bus_clk);
    #2;
    arst_n = 1'b1;
    // Nothing may come out of an idle block
    expect_idle(20);
    i = 0;
    while (i < rec_count) begin
      if (rec_space[i] != 0) begin
        run_single(i);
        i++;
      end else begin
        j = i;
        while (j < rec_count && rec_space[j] == 0) begin
          j++;
        end
        run_burst(i, j - i);
        i = j;
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/fft_patterns.txt
# header: direction mode last_pos spacing (spacing 0 back-to-back, 1 wait for output)
# then eight input samples {re,im} in hex, then eight expected bin words in hex

# Forward complex, eighth-rate tone lands in bin 1
0 0 8 1
40000000 2D412D41 00004000 D2BF2D41 C0000000 D2BFD2BF 0000C000 2D41D2BF
00000000 3FFF0000 00000000 00000000 00000000 00000000 00000000 00000000

# Inverse complex, same tone moves to bin 7
1 0 8 1
40000000 2D412D41 00004000 D2BF2D41 C0000000 D2BFD2BF 0000C000 2D41D2BF
00000000 00000000 00000000 00000000 00000000 00000000 00000000 3FFF0000

# Forward magnitude, negated tone, truncation leaves -1 in bin 5
0 1 8 1
C0000000 D2BFD2BF 0000C000 2D41D2BF 40000000 2D412D41 00004000 D2BF2D41
00000000 10000000 00000000 00000000 00000000 00000001 00000000 00000000

# Inverse magnitude, constant input in bin 0
1 1 8 1
40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000
0FFF8001 00000000 00000000 00000000 00000000 00000000 00000000 00000000

# in_last on the fifth sample, frame dropped
0 0 5 1
40000000 2D412D41 00004000 D2BF2D41 C0000000 D2BFD2BF 0000C000 2D41D2BF
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

# Good frame after the framing fault
0 0 8 1
40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000
3FFF0000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

# Three frames back-to-back, the third one overflows
0 0 8 0
40000000 2D412D41 00004000 D2BF2D41 C0000000 D2BFD2BF 0000C000 2D41D2BF
00000000 3FFF0000 00000000 00000000 00000000 00000000 00000000 00000000
0 0 8 0
C0000000 D2BFD2BF 0000C000 2D41D2BF 40000000 2D412D41 00004000 D2BF2D41
00000000 C0000000 00000000 00000000 00000000 FFFF0000 00000000 00000000
0 0 8 0
40000000 40000000 40000000 40000000 40000000 40000000 40000000 40000000
3FFF0000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// File: vlog.f
hdl/fft_pkg.sv
hdl/block_settings.sv
hdl/frame_capture.sv
hdl/sample_store.sv
hdl/dft_engine.sv
hdl/fft_block.sv
testbench/fft_block_properties.sv
testbench/fft_block_tb.sv
